/* adc_capture.sv */
`timescale 1ns/1ps

module adc_capture (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             btn_capture,
    input  logic             run,
    input  logic             adc_data,
    output logic             cs,
    output logic             spi_clk,
    output adc_pkg::sample_t sample,
    output logic             sample_valid
);

    // Divider counts 0 .. SPI_HALF - 1
    localparam int DIV_W = (adc_pkg::SPI_HALF > 1) ? $clog2(adc_pkg::SPI_HALF) : 1;
    // Bit counter has to hold FRAME_BITS itself
    localparam int BIT_W = $clog2(adc_pkg::FRAME_BITS + 1);

    logic                press;
    adc_pkg::cap_state_t state;
    logic [DIV_W-1:0]    div_q;
    logic [BIT_W-1:0]    bit_cnt;
    adc_pkg::sample_t    shift_q;
    logic                half_done;
    logic                spi_rise;
    logic                frame_last;

    button_debounce debounce (
        .clk    (clk),
        .arst_n (arst_n),
        .btn    (btn_capture),
        .press  (press)
    );

    //////////////////////////////
    // Serial clock timing
    //////////////////////////////

    // End of a half period
    assign half_done  = (div_q == DIV_W'(adc_pkg::SPI_HALF - 1));
    // spi_clk goes high on this edge
    assign spi_rise   = (state == adc_pkg::FRAME) && half_done && !spi_clk;
    // Falling edge after the last rising edge
    assign frame_last = (bit_cnt == BIT_W'(adc_pkg::FRAME_BITS));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= adc_pkg::IDLE;
            cs      <= 1'b1;
            spi_clk <= 1'b0;
            div_q   <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                adc_pkg::IDLE: begin
                    // Single shot on press, back to back while run is high
                    if (press || run) begin
                        state   <= adc_pkg::FRAME;
                        cs      <= 1'b0;
                        spi_clk <= 1'b0;
                        div_q   <= '0;
                        bit_cnt <= '0;
                    end
                end
                adc_pkg::FRAME: begin
                    if (half_done) begin
                        div_q <= '0;
                        if (!spi_clk) begin
                            spi_clk <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            spi_clk <= 1'b0;
                            // cs back high with spi_clk low
                            if (frame_last) begin
                                cs    <= 1'b1;
                                state <= adc_pkg::DONE;
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                adc_pkg::DONE: begin
                    // One cycle gap
                    state <= adc_pkg::IDLE;
                end
                default: begin
                    state <= adc_pkg::IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Data path
    //////////////////////////////

    // Leading zeros are never shifted in
    always_ff @(posedge clk) begin
        if (spi_rise && (bit_cnt >= BIT_W'(adc_pkg::LEAD_ZEROS))) begin
            shift_q <= {shift_q[adc_pkg::SAMPLE_W-2:0], adc_data};
        end
    end

    // Shift register holds the sample through DONE
    assign sample       = shift_q;
    assign sample_valid = (state == adc_pkg::DONE);

endmodule

/* adc_display_top.sv */
`timescale 1ns/1ps

module adc_display_top (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           btn_capture,
    input  logic           run,
    input  logic           adc_data,
    input  adc_pkg::addr_t view_addr,
    output logic           cs,
    output logic           spi_clk,
    output adc_pkg::seg_t  seg,
    output adc_pkg::an_t   an
);

    // Capture to RAM
    adc_pkg::sample_t sample;
    logic             sample_valid;
    // RAM to display
    adc_pkg::sample_t rd_sample;

    // Serial ADC front end
    adc_capture cap (
        .clk          (clk),
        .arst_n       (arst_n),
        .btn_capture  (btn_capture),
        .run          (run),
        .adc_data     (adc_data),
        .cs           (cs),
        .spi_clk      (spi_clk),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // Every finished sample gets written
    sample_ram ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (sample_valid),
        .wr_data (sample),
        .rd_addr (view_addr),
        .rd_data (rd_sample)
    );

    // Address and stored value on four digits
    seg7_scan scan (
        .clk       (clk),
        .arst_n    (arst_n),
        .view_addr (view_addr),
        .value     (rd_sample),
        .seg       (seg),
        .an        (an)
    );

endmodule

/* adc_patterns.txt */
// One hex word per line: bits 15:12 command, bits 9:0 ADC sample
// Command 0 button capture, 1 run mode capture (adjacent 1 lines form one burst), 2 glitch
2000
0000
03ff
0155
02aa
0001
0200
00f0
030f
2000
0123
02c4
009e
03a5
// Run burst, wraps the RAM
1111
1222
1333
10ab
13cd
11ef
// Single captures after the wrap
0246
008d
037b

/* adc_pkg.sv */
package adc_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int SAMPLE_W  = 10;
    localparam int ADDR_W    = 4;
    localparam int RAM_DEPTH = 16;

    // Serial frame: leading zeros then data, MSB first
    localparam int FRAME_BITS = 12;
    localparam int LEAD_ZEROS = 2;

    //////////////////////////////
    // Timing in clk cycles
    //////////////////////////////

    // Half period of spi_clk
    localparam int SPI_HALF       = 2;
    localparam int DEBOUNCE_TICKS = 8;
    // Time each display digit stays lit
    localparam int DIGIT_TICKS    = 16;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [3:0]          digit_t;
    // Segments active low, bit 0 is segment a
    typedef logic [6:0]          seg_t;
    // Anodes active low
    typedef logic [3:0]          an_t;

    // Capture FSM
    typedef enum logic [1:0] {
        IDLE,
        FRAME,
        DONE
    } cap_state_t;

    // Hex font, index is the nibble value
    localparam seg_t SEG_HEX [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

/* build.f */
adc_pkg.sv
button_debounce.sv
adc_capture.sv
sample_ram.sv
seg7_scan.sv
adc_display_top.sv
tb_adc_display_asserts.sv
tb_adc_display.sv

/* button_debounce.sv */
`timescale 1ns/1ps

module button_debounce (
    input  logic clk,
    input  logic arst_n,
    input  logic btn,
    output logic press
);

    // Counter must reach DEBOUNCE_TICKS - 1
    localparam int CNT_W = (adc_pkg::DEBOUNCE_TICKS > 1) ?
                           $clog2(adc_pkg::DEBOUNCE_TICKS) : 1;

    logic [1:0]       sync_q;
    logic             level_q;
    logic [CNT_W-1:0] stable_cnt;
    logic             stable_done;

    assign stable_done = (stable_cnt == CNT_W'(adc_pkg::DEBOUNCE_TICKS - 1));

    // Two flop synchronizer on the raw button
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], btn};
        end
    end

    // Count cycles the synced level differs from the accepted one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stable_cnt <= '0;
            level_q    <= 1'b0;
            press      <= 1'b0;
        end else begin
            press <= 1'b0;
            if (sync_q[1] == level_q) begin
                // Bounce back, start over
                stable_cnt <= '0;
            end else if (stable_done) begin
                stable_cnt <= '0;
                level_q    <= sync_q[1];
                // Only a rising accepted level is a press
                press      <= sync_q[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADC display testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_adc_display -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_adc_display)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* sample_ram.sv */
`timescale 1ns/1ps

module sample_ram (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  adc_pkg::sample_t wr_data,
    input  adc_pkg::addr_t   rd_addr,
    output adc_pkg::sample_t rd_data
);

    adc_pkg::sample_t mem [adc_pkg::RAM_DEPTH];
    adc_pkg::addr_t   wr_ptr;

    //////////////////////////////
    // Write side
    //////////////////////////////

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Circular pointer, wraps with the address width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            if (wr_ptr == adc_pkg::addr_t'(adc_pkg::RAM_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    // One cycle read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* seg7_scan.sv */
`timescale 1ns/1ps

module seg7_scan (
    input  logic             clk,
    input  logic             arst_n,
    input  adc_pkg::addr_t   view_addr,
    input  adc_pkg::sample_t value,
    output adc_pkg::seg_t    seg,
    output adc_pkg::an_t     an
);

    localparam int TICK_W = (adc_pkg::DIGIT_TICKS > 1) ? $clog2(adc_pkg::DIGIT_TICKS) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic [1:0]        digit_idx;
    adc_pkg::digit_t   nibble;
    logic              tick_last;

    assign tick_last = (tick_cnt == TICK_W'(adc_pkg::DIGIT_TICKS - 1));

    //////////////////////////////
    // Scan timing
    //////////////////////////////

    // Digit order 0, 1, 2, 3 then repeat
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt  <= '0;
            digit_idx <= 2'd0;
        end else if (tick_last) begin
            tick_cnt  <= '0;
            digit_idx <= digit_idx + 2'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Nibble select and decode
    //////////////////////////////

    always_comb begin
        case (digit_idx)
            2'd0:    nibble = value[3:0];
            2'd1:    nibble = value[7:4];
            // Top two sample bits, zero extended
            2'd2:    nibble = adc_pkg::digit_t'(value[adc_pkg::SAMPLE_W-1:8]);
            default: nibble = adc_pkg::digit_t'(view_addr);
        endcase
    end

    // Segments and anode change on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg <= '1;
            an  <= '1;
        end else begin
            seg <= adc_pkg::SEG_HEX[nibble];
            // One low anode per digit
            an  <= ~(adc_pkg::an_t'(1) << digit_idx);
        end
    end

endmodule

/* tb_adc_display.sv */
`timescale 1ns/1ps

module tb_adc_display;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             btn_capture;
    logic             run;
    logic             adc_data = 1'b0;
    adc_pkg::addr_t   view_addr;
    logic             cs;
    logic             spi_clk;
    adc_pkg::seg_t    seg;
    adc_pkg::an_t     an;

    // Pattern word is command in 15:12, sample in 9:0
    logic [15:0]      pat_mem [64];
    int               n_pat = 0;
    bit               loaded = 1'b0;
    bit               wrap_done = 1'b0;
    int               seed = 32'h4632_6d9e;
    int               val_errs = 0;
    int               other_errs = 0;
    // Frame monitor state
    int               starts = 0;
    int               ends = 0;
    int               low_cnt = 0;
    int               high_cnt = 0;
    int               rises = 0;
    int               last_gap = 0;
    logic             cs_prev = 1'b1;
    logic             spi_prev = 1'b0;
    // ADC model, samples waiting for a frame
    adc_pkg::sample_t adc_q [$];
    adc_pkg::sample_t cur = '0;
    int               mbit = 0;
    // Every capture in order
    adc_pkg::sample_t hist [$];

    adc_display_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .btn_capture (btn_capture),
        .run         (run),
        .adc_data    (adc_data),
        .view_addr   (view_addr),
        .cs          (cs),
        .spi_clk     (spi_clk),
        .seg         (seg),
        .an          (an)
    );

    always #2 clk = ~clk;

    task automatic check_val(input string name, input int expv, input int gotv);
        assert (gotv == expv) else begin
            val_errs++;
            $display("[FAIL] %0t %s: expected %0h, got %0h", $time, name, expv, gotv);
        end
    endtask

    task automatic report_error(input string msg);
        other_errs++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Two zeros, then the sample MSB first
    function automatic logic frame_bit(input adc_pkg::sample_t s, input int k);
        if (k < adc_pkg::LEAD_ZEROS || k >= adc_pkg::FRAME_BITS)
            return 1'b0;
        return s[adc_pkg::SAMPLE_W - 1 - (k - adc_pkg::LEAD_ZEROS)];
    endfunction

    //////////////////////////////
    // Frame monitor and ADC model
    //////////////////////////////

    always @(negedge clk) begin
        int rnd;
        rnd = $random(seed);
        if (arst_n && !cs && cs_prev) begin
            starts   <= starts + 1;
            last_gap <= high_cnt;
            low_cnt  <= 1;
            rises    <= 0;
            assert (adc_q.size() > 0) else
                report_error("frame started with no sample queued");
            if (adc_q.size() > 0)
                cur = adc_q.pop_front();
            // First bit goes out with cs
            mbit     = 0;
            adc_data = frame_bit(cur, 0);
        end else if (arst_n && !cs) begin
            low_cnt <= low_cnt + 1;
            if (spi_clk && !spi_prev)
                rises <= rises + 1;
            // Next bit after each falling spi_clk
            if (!spi_clk && spi_prev) begin
                mbit     = mbit + 1;
                adc_data = frame_bit(cur, mbit);
            end
        end else begin
            if (arst_n && !cs_prev) begin
                check_val("cs low cycles",
                          adc_pkg::FRAME_BITS * 2 * adc_pkg::SPI_HALF, low_cnt);
                check_val("spi_clk rising edges", adc_pkg::FRAME_BITS, rises);
                ends     <= ends + 1;
                high_cnt <= 1;
            end else begin
                high_cnt <= high_cnt + 1;
            end
            // Noise on the idle line
            adc_data = rnd[0];
        end
        cs_prev  <= cs;
        spi_prev <= spi_clk;
    end

    task automatic wait_frames(input bit on_end, input int target);
        int n;
        n = 0;
        while ((on_end ? ends : starts) < target && n < 200) begin
            @(negedge clk);
            n++;
        end
        assert ((on_end ? ends : starts) >= target) else
            report_error(on_end ? "frame never ended" : "frame never started");
    endtask

    // Reads the four digits back through the hex font
    task automatic check_display(input adc_pkg::addr_t a, input adc_pkg::sample_t s);
        adc_pkg::an_t want;
        int           exp_d;
        int           got;
        int           n;
        view_addr = a;
        // RAM read, then segment register
        repeat (3) @(negedge clk);
        for (int d = 0; d < 4; d++) begin
            want    = '1;
            want[d] = 1'b0;
            n       = 0;
            while (an !== want && n < 4 * adc_pkg::DIGIT_TICKS) begin
                @(negedge clk);
                n++;
            end
            assert (an === want) else
                report_error($sformatf("anode of digit %0d never selected", d));
            // No match leaves -1
            got = -1;
            for (int k = 0; k < 16; k++)
                if (seg == adc_pkg::SEG_HEX[k])
                    got = k;
            case (d)
                0:       exp_d = int'(s[3:0]);
                1:       exp_d = int'(s[7:4]);
                2:       exp_d = int'(s[9:8]);
                default: exp_d = int'(a);
            endcase
            check_val($sformatf("seg digit %0d", d), exp_d, got);
        end
    endtask

    // One button capture, or a run burst of several frames
    task automatic capture_burst(input int first, input int last, input bit use_run);
        int             s0;
        int             e0;
        int             n;
        adc_pkg::addr_t idx;
        s0 = starts;
        e0 = ends;
        n  = last - first;
        for (int k = 0; k < n; k++)
            adc_q.push_back(pat_mem[first + k][9:0]);
        if (use_run) begin
            run = 1'b1;
        end else begin
            btn_capture = 1'b1;
            repeat (20) @(negedge clk);
            btn_capture = 1'b0;
        end
        for (int k = 0; k < n; k++) begin
            wait_frames(1'b0, s0 + k + 1);
            // Back to back spacing
            if (k > 0)
                check_val("cs high gap", 2, last_gap);
        end
        run = 1'b0;
        wait_frames(1'b1, e0 + n);
        repeat (4) @(negedge clk);
        assert (starts == s0 + n) else
            report_error($sformatf("%0d frames started, %0d were due", starts - s0, n));
        for (int k = 0; k < n; k++) begin
            idx = adc_pkg::addr_t'(hist.size() % adc_pkg::RAM_DEPTH);
            hist.push_back(pat_mem[first + k][9:0]);
            check_display(idx, pat_mem[first + k][9:0]);
        end
    endtask

    task automatic short_press();
        int s0;
        s0 = starts;
        // Shorter than the debounce window
        btn_capture = 1'b1;
        repeat (adc_pkg::DEBOUNCE_TICKS - 3) @(negedge clk);
        btn_capture = 1'b0;
        repeat (4 * adc_pkg::DEBOUNCE_TICKS) @(negedge clk);
        assert (starts == s0 && cs) else
            report_error("short button pulse started a frame");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int i;
        int j;
        arst_n      = 1'b0;
        btn_capture = 1'b0;
        run         = 1'b0;
        view_addr   = '0;
        for (i = 0; i < 64; i++)
            pat_mem[i] = 16'hFFFF;
        $readmemh("adc_patterns.txt", pat_mem);
        while (n_pat < 64 && pat_mem[n_pat] != 16'hFFFF)
            n_pat++;
        loaded = 1'b1;
        assert (n_pat > 0) else
            report_error("pattern file gave no entries");
        repeat (4) @(negedge clk);
        check_val("cs", 1, int'(cs));
        check_val("spi_clk", 0, int'(spi_clk));
        check_val("an", 4'hF, int'(an));
        check_val("seg", 7'h7F, int'(seg));
        arst_n = 1'b1;
        @(negedge clk);
        // Scan begins on digit 0
        check_val("cs", 1, int'(cs));
        check_val("spi_clk", 0, int'(spi_clk));
        check_val("an", 4'b1110, int'(an));
        i = 0;
        while (i < n_pat) begin
            j = i + 1;
            assert (pat_mem[i][15:12] <= 4'h2) else
                report_error($sformatf("unknown command in pattern %0d", i));
            case (pat_mem[i][15:12])
                4'h0: capture_burst(i, j, 1'b0);
                4'h1: begin
                    while (j < n_pat && pat_mem[j][15:12] == 4'h1)
                        j++;
                    capture_burst(i, j, 1'b1);
                end
                4'h2: short_press();
                default: ;
            endcase
            // RAM wrapped, entries 0 and 1 overwritten
            if (!wrap_done && hist.size() >= 18) begin
                check_display(4'd0, hist[16]);
                check_display(4'd1, hist[17]);
                wrap_done = 1'b1;
            end
            i = j;
        end
        assert (wrap_done) else
            report_error("fewer than 18 captures, RAM wrap never checked");
        $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat ((n_pat + 20) * 200) @(posedge clk);
        $display("Watchdog expired after %0d clk cycles", (n_pat + 20) * 200);
        $display("tests failed");
        $finish;
    end

endmodule

/* tb_adc_display_asserts.sv */
`timescale 1ns/1ps

module tb_adc_display_asserts #(
    // 1 watches the serial side, 0 the anode scan
    parameter bit CAP_SIDE = 1'b1
) (
    input logic         clk,
    input logic         arst_n,
    input logic         cs,
    input logic         spi_clk,
    input logic         sample_valid,
    input adc_pkg::an_t an
);

    generate
        if (CAP_SIDE) begin : g_cap
            // Serial clock parks low between frames
            cs_high_spi_low: assert property (@(posedge clk) disable iff (!arst_n)
                cs |-> !spi_clk)
                else $error("spi_clk high while cs is high");

            // Strobe lines up with the end of a frame
            valid_on_cs_rise: assert property (@(posedge clk) disable iff (!arst_n)
                sample_valid |-> $rose(cs))
                else $error("sample_valid without cs rising");

            valid_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
                sample_valid |=> !sample_valid)
                else $error("sample_valid longer than one cycle");
        end else begin : g_scan
            // One digit lit once the scan runs
            one_anode_low: assert property (@(posedge clk) disable iff (!arst_n)
                $past(arst_n) |-> ($countones(~an) == 1))
                else $error("an selects other than exactly one digit");
        end
    endgenerate

endmodule

// Serial bus and strobe on the capture side
bind adc_capture tb_adc_display_asserts #(.CAP_SIDE(1'b1)) cap_asserts (
    .clk          (clk),
    .arst_n       (arst_n),
    .cs           (cs),
    .spi_clk      (spi_clk),
    .sample_valid (sample_valid),
    .an           (4'b1111)
);
// Anode scan on the display side
bind seg7_scan tb_adc_display_asserts #(.CAP_SIDE(1'b0)) scan_asserts (
    .clk          (clk),
    .arst_n       (arst_n),
    .cs           (1'b1),
    .spi_clk      (1'b0),
    .sample_valid (1'b0),
    .an           (an)
);
